//--- verilog/sprite_defs.svh
`default_nettype none
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// 800x600 grid, blanking folded into the totals
`define H_ACTIVE    800   // visible columns
`define H_TOTAL     1056  // columns per line incl blanking
`define V_ACTIVE    600   // visible lines
`define V_TOTAL     628   // lines per frame incl blanking

`define FRUIT_SIZE  25    // fruit square edge
`define HEART_SIZE  16    // heart square edge

`define FRUIT_X0    400   // fruit position after reset
`define FRUIT_Y0    400

// lives row, top right corner
`define HEART1_X    717
`define HEART2_X    734
`define HEART3_X    751
`define HEART_Y     30

`define BARRIER_W   8     // edge band thickness

`endif
`default_nettype wire

//--- verilog/sprite_pkg.sv
`default_nettype none
package sprite_pkg;

	typedef logic [4:0] element_t; // sprite memory select

	localparam element_t ELEM_NONE    = 5'd0;  // nothing drawn
	localparam element_t ELEM_FRUIT   = 5'd1;
	localparam element_t ELEM_HEART   = 5'd2;
	localparam element_t ELEM_BARRIER = 5'd5;  // border tiles

	typedef enum logic [2:0] {
		ST_IDLE  = 3'd0, // title screen, border only
		ST_PLAY  = 3'd1, // everything visible
		ST_PAUSE = 3'd2,
		ST_OVER  = 3'd3
	} game_state_e;

	typedef enum logic {
		REG_CTRL  = 1'b0, // state and lives
		REG_FRUIT = 1'b1  // fruit position, shadowed
	} reg_addr_e;

	typedef struct packed {
		logic [10:0] x;
		logic [9:0]  y;
	} pos_t;

	typedef struct packed {
		logic [15:0] pad;   // unused upper bits
		logic [1:0]  lives;
		game_state_e state;
	} ctrl_t;

	// one write word, meaning picked by the register address
	typedef union packed {
		pos_t  pos;
		ctrl_t ctrl;
	} cfg_word_u;

endpackage
`default_nettype wire

//--- verilog/scan_if.sv
`timescale 1ns/1ns
`default_nettype none
interface scan_if;
	logic [10:0] pixel_x;     // current column
	logic [9:0]  pixel_y;     // current line
	logic        active;      // inside visible area
	logic        frame_start; // last position of frame, one cycle

	modport src (
		output pixel_x,
		output pixel_y,
		output active,
		output frame_start
	);

	modport snk (
		input pixel_x,
		input pixel_y,
		input active,
		input frame_start
	);
endinterface
`default_nettype wire

//--- verilog/vga_scan.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"
`default_nettype none
module vga_scan (
	input  wire clk,
	input  wire rst,
	scan_if.src scan
);

	logic [10:0] h_cnt;  // column counter
	logic [9:0]  v_cnt;  // line counter
	logic        h_last; // end of line
	logic        v_last; // end of frame, in lines

	assign h_last = (h_cnt == 11'(`H_TOTAL - 1));
	assign v_last = (v_cnt == 10'(`V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0; // wrap column
			if (v_last) begin
				v_cnt <= '0; // back to top
			end else begin
				v_cnt <= v_cnt + 10'd1;
			end
		end else begin
			h_cnt <= h_cnt + 11'd1;
		end
	end

	assign scan.pixel_x = h_cnt;
	assign scan.pixel_y = v_cnt;
	// visible window starts at the origin, blanking trails it
	assign scan.active = (h_cnt < 11'(`H_ACTIVE)) && (v_cnt < 10'(`V_ACTIVE));
	assign scan.frame_start = h_last && v_last; // shadow copy point

	// column counter never leaves the line
	a_x_range: assert property (@(posedge clk) disable iff (rst)
		scan.pixel_x < 11'(`H_TOTAL));

endmodule
`default_nettype wire

//--- verilog/sprite_regs.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"
`default_nettype none
module sprite_regs (
	input  wire                   clk,
	input  wire                   rst,
	scan_if.snk                   scan,
	input  wire                   wr_en,
	input  wire sprite_pkg::reg_addr_e wr_addr,
	input  wire sprite_pkg::cfg_word_u wr_data,
	output sprite_pkg::game_state_e    state,
	output logic [1:0]            lives,
	output sprite_pkg::pos_t           fruit_pos
);

	import sprite_pkg::*;

	pos_t fruit_pend; // written position, waits for frame edge

	// control word, visible the cycle after the write
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			lives <= 2'd3; // full health
		end else if (wr_en && wr_addr == REG_CTRL) begin
			state <= wr_data.ctrl.state;
			lives <= wr_data.ctrl.lives;
		end
	end

	// fruit position, double buffered
	always_ff @(posedge clk) begin
		if (rst) begin
			fruit_pend.x <= 11'(`FRUIT_X0);
			fruit_pend.y <= 10'(`FRUIT_Y0);
			fruit_pos.x  <= 11'(`FRUIT_X0);
			fruit_pos.y  <= 10'(`FRUIT_Y0);
		end else begin
			if (wr_en && wr_addr == REG_FRUIT) begin
				fruit_pend <= wr_data.pos; // same word read as x/y
			end
			if (scan.frame_start) begin
				fruit_pos <= fruit_pend; // no tearing mid frame
			end
		end
	end

	// a lives value of 4 or more would spill into the spare bits
	a_lives_write: assert property (@(posedge clk) disable iff (rst)
		wr_en && wr_addr == REG_CTRL
		|-> {wr_data.ctrl.pad, wr_data.ctrl.lives} <= 18'd3);

endmodule
`default_nettype wire

//--- verilog/sprite_window.sv
`timescale 1ns/1ns
`default_nettype none
module sprite_window #(
	parameter int                   SIZE = 16,                   // square edge in pixels
	parameter sprite_pkg::element_t ELEM = sprite_pkg::ELEM_HEART // code reported on hit
) (
	scan_if.snk                    scan,
	input  wire sprite_pkg::pos_t  pos,
	output logic                   hit,
	output sprite_pkg::element_t   element,
	output logic [9:0]             address
);

	logic [11:0] x_end; // one past right edge, extra bit vs overflow
	logic [10:0] y_end; // one past bottom edge
	logic        in_x;
	logic        in_y;
	logic [9:0]  col;   // offset into sprite
	logic [9:0]  row;

	assign x_end = {1'b0, pos.x} + 12'(SIZE);
	assign y_end = {1'b0, pos.y} + 11'(SIZE);

	assign in_x = (scan.pixel_x >= pos.x) && ({1'b0, scan.pixel_x} < x_end);
	assign in_y = (scan.pixel_y >= pos.y) && ({1'b0, scan.pixel_y} < y_end);

	assign hit = scan.active && in_x && in_y;

	// only meaningful inside the square, so truncation is safe
	assign col = 10'(scan.pixel_x - pos.x);
	assign row = scan.pixel_y - pos.y;

	assign address = row * 10'(SIZE) + col; // row-major sprite memory
	assign element = ELEM;

endmodule
`default_nettype wire

//--- verilog/barrier_border.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"
`default_nettype none
module barrier_border (
	scan_if.snk        scan,
	output logic       hit,
	output logic [9:0] address
);

	logic edge_l; // band flags per screen side
	logic edge_r;
	logic edge_t;
	logic edge_b;

	assign edge_l = scan.pixel_x < 11'(`BARRIER_W);
	assign edge_r = scan.pixel_x >= 11'(`H_ACTIVE - `BARRIER_W);
	assign edge_t = scan.pixel_y < 10'(`BARRIER_W);
	assign edge_b = scan.pixel_y >= 10'(`V_ACTIVE - `BARRIER_W);

	// blanking excluded, right/bottom bands are relative to visible size
	assign hit = scan.active && (edge_l || edge_r || edge_t || edge_b);

	// 32x32 tile repeats across the band
	assign address = {scan.pixel_y[4:0], scan.pixel_x[4:0]};

endmodule
`default_nettype wire

//--- verilog/element_select.sv
`timescale 1ns/1ns
`default_nettype none
module element_select (
	input  wire                       clk,
	input  wire                       rst,
	scan_if.snk                       scan,
	input  wire sprite_pkg::game_state_e state,
	input  wire [1:0]                 lives,
	input  wire                       barrier_hit,
	input  wire [9:0]                 barrier_addr,
	input  wire                       fruit_hit,
	input  wire sprite_pkg::element_t fruit_elem,
	input  wire [9:0]                 fruit_addr,
	input  wire                       heart1_hit,
	input  wire sprite_pkg::element_t heart1_elem,
	input  wire [9:0]                 heart1_addr,
	input  wire                       heart2_hit,
	input  wire sprite_pkg::element_t heart2_elem,
	input  wire [9:0]                 heart2_addr,
	input  wire                       heart3_hit,
	input  wire sprite_pkg::element_t heart3_elem,
	input  wire [9:0]                 heart3_addr,
	output sprite_pkg::element_t      element,
	output logic [9:0]                address,
	output logic                      ready
);

	import sprite_pkg::*;

	logic     playing;  // sprites only drawn in play
	element_t sel_elem; // combinational winner
	logic [9:0] sel_addr;
	logic     sel_hit;

	assign playing = (state == ST_PLAY);

	always_comb begin
		sel_elem = ELEM_NONE;
		sel_addr = '0;
		sel_hit  = 1'b0;
		if (barrier_hit) begin // border beats everything, any state
			sel_elem = ELEM_BARRIER;
			sel_addr = barrier_addr;
			sel_hit  = 1'b1;
		end else if (playing && fruit_hit) begin
			sel_elem = fruit_elem;
			sel_addr = fruit_addr;
			sel_hit  = 1'b1;
		end else if (playing && heart1_hit && lives >= 2'd1) begin
			sel_elem = heart1_elem;
			sel_addr = heart1_addr;
			sel_hit  = 1'b1;
		end else if (playing && heart2_hit && lives >= 2'd2) begin
			sel_elem = heart2_elem;
			sel_addr = heart2_addr;
			sel_hit  = 1'b1;
		end else if (playing && heart3_hit && lives == 2'd3) begin
			sel_elem = heart3_elem;
			sel_addr = heart3_addr;
			sel_hit  = 1'b1;
		end
	end

	// one cycle behind the scan position
	always_ff @(posedge clk) begin
		if (rst || !scan.active) begin // blanking forces zeros
			element <= ELEM_NONE;
			address <= '0;
			ready   <= 1'b0;
		end else begin
			element <= sel_elem;
			address <= sel_addr;
			ready   <= sel_hit;
		end
	end

	// downstream may sample element/address without looking at ready
	a_idle_zero: assert property (@(posedge clk) disable iff (rst)
		!ready |-> element == ELEM_NONE && address == '0);

endmodule
`default_nettype wire

//--- verilog/sprite_render_top.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"
`default_nettype none
module sprite_render_top (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        wr_en,
	input  wire sprite_pkg::reg_addr_e wr_addr,
	input  wire sprite_pkg::cfg_word_u wr_data,
	output logic [10:0]                pixel_x,
	output logic [9:0]                 pixel_y,
	output logic                       active,
	output sprite_pkg::element_t       element,
	output logic [9:0]                 address,
	output logic                       ready
);

	import sprite_pkg::*;

	// hearts never move
	localparam pos_t HEART1_POS = '{x: 11'(`HEART1_X), y: 10'(`HEART_Y)};
	localparam pos_t HEART2_POS = '{x: 11'(`HEART2_X), y: 10'(`HEART_Y)};
	localparam pos_t HEART3_POS = '{x: 11'(`HEART3_X), y: 10'(`HEART_Y)};

	game_state_e state;
	logic [1:0]  lives;
	pos_t        fruit_pos;  // live copy, frame aligned

	logic        barrier_hit;
	logic [9:0]  barrier_addr;
	logic        fruit_hit;
	element_t    fruit_elem;
	logic [9:0]  fruit_addr;
	logic        heart1_hit;
	element_t    heart1_elem;
	logic [9:0]  heart1_addr;
	logic        heart2_hit;
	element_t    heart2_elem;
	logic [9:0]  heart2_addr;
	logic        heart3_hit;
	element_t    heart3_elem;
	logic [9:0]  heart3_addr;

	scan_if scan ();

	vga_scan scan_gen (.clk(clk), .rst(rst), .scan(scan.src));

	sprite_regs regs (
		.clk(clk), .rst(rst), .scan(scan.snk),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.state(state), .lives(lives), .fruit_pos(fruit_pos)
	);

	sprite_window #(.SIZE(`FRUIT_SIZE), .ELEM(ELEM_FRUIT)) fruit_win (
		.scan(scan.snk), .pos(fruit_pos),
		.hit(fruit_hit), .element(fruit_elem), .address(fruit_addr)
	);

	sprite_window #(.SIZE(`HEART_SIZE), .ELEM(ELEM_HEART)) heart1_win (
		.scan(scan.snk), .pos(HEART1_POS),
		.hit(heart1_hit), .element(heart1_elem), .address(heart1_addr)
	);

	sprite_window #(.SIZE(`HEART_SIZE), .ELEM(ELEM_HEART)) heart2_win (
		.scan(scan.snk), .pos(HEART2_POS),
		.hit(heart2_hit), .element(heart2_elem), .address(heart2_addr)
	);

	sprite_window #(.SIZE(`HEART_SIZE), .ELEM(ELEM_HEART)) heart3_win (
		.scan(scan.snk), .pos(HEART3_POS),
		.hit(heart3_hit), .element(heart3_elem), .address(heart3_addr)
	);

	barrier_border border (.scan(scan.snk), .hit(barrier_hit), .address(barrier_addr));

	element_select sel (
		.clk(clk), .rst(rst), .scan(scan.snk),
		.state(state), .lives(lives),
		.barrier_hit(barrier_hit), .barrier_addr(barrier_addr),
		.fruit_hit(fruit_hit), .fruit_elem(fruit_elem), .fruit_addr(fruit_addr),
		.heart1_hit(heart1_hit), .heart1_elem(heart1_elem), .heart1_addr(heart1_addr),
		.heart2_hit(heart2_hit), .heart2_elem(heart2_elem), .heart2_addr(heart2_addr),
		.heart3_hit(heart3_hit), .heart3_elem(heart3_elem), .heart3_addr(heart3_addr),
		.element(element), .address(address), .ready(ready)
	);

	// scan position leaves same cycle, pixel data one later
	assign pixel_x = scan.pixel_x;
	assign pixel_y = scan.pixel_y;
	assign active  = scan.active;

endmodule
`default_nettype wire

//--- verif/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none
module tb_clock #(
	parameter int PERIOD       = 40, // ns
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// release on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
	end

endmodule
`default_nettype wire

//--- verif/tb_checker.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"
`default_nettype none
module tb_checker (
	input  wire                        clk,
	input  wire                        rst,
	input  wire [2:0]                  test_id,
	input  wire                        wr_en,
	input  wire sprite_pkg::reg_addr_e wr_addr,
	input  wire sprite_pkg::cfg_word_u wr_data,
	input  wire [10:0]                 pixel_x,
	input  wire [9:0]                  pixel_y,
	input  wire                        active,
	input  wire sprite_pkg::element_t  element,
	input  wire [9:0]                  address,
	input  wire                        ready,
	output int                         n_checks,
	output int                         n_errors,
	output int                         n_other
);

	import sprite_pkg::*;

	game_state_e m_state;   // mirrored registers
	logic [1:0]  m_lives;
	pos_t        m_pend;    // written fruit, waits for frame edge
	pos_t        m_fruit;
	int          cur_x;     // scan position seen before the edge
	int          cur_y;
	int          exp_x;     // scan position counted from reset
	int          exp_y;
	logic [15:0] exp_word;  // {ready, element, address}
	logic        exp_valid;

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0: return "reset";
			3'd1: return "idle";
			3'd2: return "play";
			3'd3: return "lives_state";
			3'd4: return "fruit_move";
			default: return "random";
		endcase
	endfunction

	// what the compositor should show for one pixel
	function automatic logic [15:0] expect_pixel(input int x, input int y,
			input game_state_e st, input int lives, input int fx, input int fy);
		int hx;
		if (x >= `H_ACTIVE || y >= `V_ACTIVE) return 16'd0; // blanking
		if (x < `BARRIER_W || x >= `H_ACTIVE - `BARRIER_W
				|| y < `BARRIER_W || y >= `V_ACTIVE - `BARRIER_W)
			return {1'b1, ELEM_BARRIER, y[4:0], x[4:0]};
		if (st != ST_PLAY) return 16'd0;
		if (x >= fx && x < fx + `FRUIT_SIZE && y >= fy && y < fy + `FRUIT_SIZE)
			return {1'b1, ELEM_FRUIT, 10'((y - fy) * `FRUIT_SIZE + x - fx)};
		for (int k = 1; k <= 3; k++) begin
			hx = (k == 1) ? `HEART1_X : (k == 2) ? `HEART2_X : `HEART3_X;
			if (lives >= k && x >= hx && x < hx + `HEART_SIZE
					&& y >= `HEART_Y && y < `HEART_Y + `HEART_SIZE)
				return {1'b1, ELEM_HEART, 10'((y - `HEART_Y) * `HEART_SIZE + x - hx)};
		end
		return 16'd0;
	endfunction

	initial begin
		n_checks  = 0;
		n_errors  = 0;
		n_other   = 0;
		exp_valid = 1'b0;
		cur_x     = 0;
		cur_y     = 0;
		exp_x     = 0;
		exp_y     = 0;
	end

	// model update, inputs are stable here
	always @(posedge clk) begin
		exp_valid = 1'b1;
		if (rst) begin
			exp_word  = 16'd0;
			exp_x     = 0;
			exp_y     = 0;
			m_state   = ST_IDLE;
			m_lives   = 2'd3;
			m_pend.x  = 11'(`FRUIT_X0);
			m_pend.y  = 10'(`FRUIT_Y0);
			m_fruit   = m_pend;
		end else begin
			exp_word = expect_pixel(cur_x, cur_y, m_state, m_lives, m_fruit.x, m_fruit.y);
			if (exp_x == `H_TOTAL - 1) begin // raster wrap
				exp_x = 0;
				exp_y = (exp_y == `V_TOTAL - 1) ? 0 : exp_y + 1;
			end else begin
				exp_x++;
			end
			if (cur_x == `H_TOTAL - 1 && cur_y == `V_TOTAL - 1)
				m_fruit = m_pend; // copy before this edge's write
			if (wr_en && wr_addr == REG_FRUIT)
				m_pend = wr_data.pos;
			if (wr_en && wr_addr == REG_CTRL) begin
				m_state = wr_data.ctrl.state;
				m_lives = wr_data.ctrl.lives;
			end
		end
	end

	// compare registered outputs mid cycle
	always @(negedge clk) begin
		if (exp_valid) begin
			n_checks++;
			if ($isunknown({ready, element, address})) begin
				n_other++;
				if (n_other <= 50)
					$display("%s: outputs went unknown after pixel %0d,%0d",
						test_name(test_id), cur_x, cur_y);
			end else if ({ready, element, address} !== exp_word) begin
				n_errors++;
				if (n_errors <= 50) // a real bug floods, counts still kept
					$display("error %s pixel %0d,%0d expected %0d/%0d/%0d actual %0d/%0d/%0d",
						test_name(test_id), cur_x, cur_y, exp_word[15], exp_word[14:10],
						exp_word[9:0], ready, element, address);
			end
		end
		if (!rst && (pixel_x !== 11'(exp_x) || pixel_y !== 10'(exp_y))) begin
			n_errors++;
			if (n_errors <= 50)
				$display("error %s position expected %0d,%0d actual %0d,%0d",
					test_name(test_id), exp_x, exp_y, pixel_x, pixel_y);
		end
		if (!rst && active !== (pixel_x < `H_ACTIVE && pixel_y < `V_ACTIVE)) begin
			n_errors++;
			if (n_errors <= 50)
				$display("error %s active at %0d,%0d expected %0d actual %0d", test_name(test_id),
					pixel_x, pixel_y, pixel_x < `H_ACTIVE && pixel_y < `V_ACTIVE, active);
		end
		cur_x = pixel_x; // position the next edge registers
		cur_y = pixel_y;
	end

endmodule
`default_nettype wire

//--- verif/sprite_render_tb.sv
`timescale 1ns/1ns
`include "sprite_defs.svh"
`default_nettype none
module sprite_render_tb;

	import sprite_pkg::*;

	localparam longint FRAME_NS    = longint'(`H_TOTAL) * `V_TOTAL * 40;
	localparam int     TEST_FRAMES = 7; // idle, play, lives+move x2, random x3
	localparam longint WATCHDOG_NS = (TEST_FRAMES + 1) * FRAME_NS;

	logic        clk;
	logic        rst;
	logic        wr_en;
	reg_addr_e   wr_addr;
	cfg_word_u   wr_data;
	logic [10:0] pixel_x;
	logic [9:0]  pixel_y;
	logic        active;
	element_t    element;
	logic [9:0]  address;
	logic        ready;
	logic [2:0]  test_id;   // names the running test in error lines
	int          n_checks;
	int          n_errors;
	int          n_other;
	logic [31:0] lfsr;
	logic [31:0] rx;
	logic [31:0] ry;
	logic [31:0] rl;

	tb_clock #(.PERIOD(40), .RESET_CYCLES(5)) clk_gen (.clk(clk), .rst(rst));

	sprite_render_top dut0 (
		.clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .active(active),
		.element(element), .address(address), .ready(ready)
	);

	tb_checker chk (
		.clk(clk), .rst(rst), .test_id(test_id),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.pixel_x(pixel_x), .pixel_y(pixel_y), .active(active),
		.element(element), .address(address), .ready(ready),
		.n_checks(n_checks), .n_errors(n_errors), .n_other(n_other)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// one cycle strobe, called right after a falling edge
	task automatic write_word(input reg_addr_e a, input cfg_word_u d);
		wr_en   = 1'b1;
		wr_addr = a;
		wr_data = d;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic set_ctrl(input game_state_e st, input logic [1:0] lives);
		cfg_word_u w;
		w.ctrl.pad   = '0;
		w.ctrl.lives = lives;
		w.ctrl.state = st;
		write_word(REG_CTRL, w);
	endtask

	task automatic set_fruit(input logic [10:0] x, input logic [9:0] y);
		cfg_word_u w;
		w.pos.x = x;
		w.pos.y = y;
		write_word(REG_FRUIT, w);
	endtask

	task automatic wait_line(input int y);
		while (!(pixel_y == y && pixel_x == 0)) @(negedge clk);
	endtask

	// returns at 0,0 of the next frame
	task automatic wait_frame_end();
		while (!(pixel_x == `H_TOTAL - 1 && pixel_y == `V_TOTAL - 1)) @(negedge clk);
		@(negedge clk);
	endtask

	initial begin
		wr_en   = 1'b0;
		wr_addr = REG_CTRL;
		wr_data = '0;
		test_id = 3'd0;
		lfsr    = 32'h7bd0_54e2;
		wait (rst === 1'b0);
		@(negedge clk);
		test_id = 3'd1;  // reset defaults, border only
		wait_frame_end();
		test_id = 3'd2;
		set_ctrl(ST_PLAY, 2'd3);
		wait_frame_end();
		test_id = 3'd3;  // hearts span lines 30..45, one setting per band
		set_ctrl(ST_PLAY, 2'd2);
		wait_line(34);
		set_ctrl(ST_PLAY, 2'd1);
		wait_line(38);
		set_ctrl(ST_PLAY, 2'd0);
		wait_line(42);
		set_ctrl(ST_PAUSE, 2'd3);
		wait_line(46);
		set_ctrl(ST_PLAY, 2'd3);
		test_id = 3'd4;  // fruit still at default this frame
		wait_line(200);
		set_fruit(11'd100, 10'd300);
		wait_frame_end();
		wait_line(310);  // moved fruit spans lines 300..324
		test_id = 3'd3;  // pause hides the middle band of the fruit
		set_ctrl(ST_PAUSE, 2'd3);
		wait_line(316);
		set_ctrl(ST_PLAY, 2'd3);
		test_id = 3'd4;
		wait_frame_end();
		test_id = 3'd5;
		repeat (3) begin
			take_bits(10, rx);
			take_bits(9, ry);
			take_bits(2, rl);
			set_fruit(rx[10:0], ry[9:0]);
			set_ctrl(ST_PLAY, rl[1:0]);
			wait_frame_end();
		end
		repeat (2) @(negedge clk);
		$display("checks %0d, value errors %0d, other errors %0d", n_checks, n_errors, n_other);
		if (n_errors == 0 && n_other == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, tests still running after %0d frame times", TEST_FRAMES + 1);
		$display("Test failures found");
		$finish;
	end

endmodule
`default_nettype wire

//--- sprite_render.f
+incdir+verilog
verilog/sprite_pkg.sv
verilog/scan_if.sv
verilog/vga_scan.sv
verilog/sprite_regs.sv
verilog/sprite_window.sv
verilog/barrier_border.sv
verilog/element_select.sv
verilog/sprite_render_top.sv
verif/tb_clock.sv
verif/tb_checker.sv
verif/sprite_render_tb.sv

//--- Bender.yml
package:
  name: sprite_render

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/sprite_pkg.sv
      - verilog/scan_if.sv
      - verilog/vga_scan.sv
      - verilog/sprite_regs.sv
      - verilog/sprite_window.sv
      - verilog/barrier_border.sv
      - verilog/element_select.sv
      - verilog/sprite_render_top.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_checker.sv
      - verif/sprite_render_tb.sv
